/* verilog.f */
exec_pkg.sv
alu_unit.sv
mul_stage.sv
issue_unit.sv
reorder_buffer.sv
exec_core.sv
exec_core_properties.sv
exec_core_tb.sv

/* exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb;
  import exec_pkg::*;

  localparam int NUM_OFFERS       = 2000;
  localparam int RESET_CYCLES     = 10;
  localparam int CLK_PERIOD       = 4;
  localparam int CYCLES_PER_OFFER = MUL_STAGES + ROB_DEPTH + 4;
  localparam int TIMEOUT_NS       = (NUM_OFFERS * CYCLES_PER_OFFER + RESET_CYCLES) * CLK_PERIOD;

  typedef struct packed {
    logic [REG_WIDTH-1:0]  rd;
    logic [DATA_WIDTH-1:0] value;
  } expect_t;

  logic      clk_i;
  logic      rst_i;
  logic      issue_valid_i;
  issue_op_t issue_op_i;
  logic      stall_o;
  commit_t   commit_o;

  integer                seed = 32'h88f411ba;
  expect_t               exp_q [$];
  logic [MUL_STAGES-2:0] mul_age;
  int                    accept_count;
  int                    commit_count;
  int                    value_errors;
  int                    other_errors;
  int                    collision_stalls;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  exec_core dut0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_op_i    (issue_op_i),
    .stall_o       (stall_o),
    .commit_o      (commit_o)
  );

  // ========================================
  // Reference model
  // ========================================
  function automatic logic [DATA_WIDTH-1:0] model_result(input issue_op_t op);
    logic [4:0]              shamt;
    logic [2*DATA_WIDTH-1:0] product;
    shamt   = op.src_b[4:0];
    product = op.src_a * op.src_b;
    case (op.kind)
      OP_ADD:  model_result = op.src_a + op.src_b;
      OP_SUB:  model_result = op.src_a - op.src_b;
      OP_AND:  model_result = op.src_a & op.src_b;
      OP_OR:   model_result = op.src_a | op.src_b;
      OP_XOR:  model_result = op.src_a ^ op.src_b;
      OP_SLL:  model_result = op.src_a << shamt;
      OP_SRL:  model_result = op.src_a >> shamt;
      default: model_result = product[DATA_WIDTH-1:0];
    endcase
  endfunction

  // Commit checks, stall prediction and acceptance tracking
  always @(posedge clk_i) begin : monitor
    expect_t entry;
    logic    exp_stall;
    logic    is_alu;
    logic    accepted;
    if (rst_i) begin
      assert (!$isunknown(commit_o.valid)) else begin
        other_errors++;
        $display("t=%0t commit_o.valid is unknown", $time);
      end
      if (commit_o.valid === 1'b1) begin
        assert (exp_q.size() > 0) else begin
          other_errors++;
          $display("t=%0t commit seen with no accepted operation outstanding", $time);
        end
        if (exp_q.size() > 0) begin
          entry = exp_q.pop_front();
          commit_count++;
          assert (commit_o.rd === entry.rd) else begin
            value_errors++;
            $display("ERR t=%0t commit_o.rd expected %0d got %0d",
                     $time, entry.rd, commit_o.rd);
          end
          assert (commit_o.result === entry.value) else begin
            value_errors++;
            $display("ERR t=%0t commit_o.result expected %08h got %08h",
                     $time, entry.value, commit_o.result);
          end
        end
      end

      // Full ROB, or an ALU result landing on a multiply writeback
      is_alu    = (issue_op_i.kind != OP_MUL);
      exp_stall = (exp_q.size() == ROB_DEPTH) || (is_alu && mul_age[MUL_STAGES-2]);
      assert (stall_o === exp_stall) else begin
        value_errors++;
        $display("ERR t=%0t stall_o expected %0b got %0b", $time, exp_stall, stall_o);
      end

      accepted = issue_valid_i && (stall_o === 1'b0);
      if (issue_valid_i && stall_o === 1'b1 && exp_q.size() < ROB_DEPTH) begin
        collision_stalls++;
      end
      if (accepted) begin
        assert (exp_q.size() < ROB_DEPTH) else begin
          other_errors++;
          $display("t=%0t operation accepted with %0d already outstanding",
                   $time, exp_q.size());
        end
        entry.rd    = issue_op_i.rd;
        entry.value = model_result(issue_op_i);
        exp_q.push_back(entry);
        accept_count++;
      end
      mul_age = (mul_age << 1) | (accepted && !is_alu);
    end else begin
      mul_age = '0;
    end
  end

  // ========================================
  // Stimulus
  // ========================================
  task automatic random_op(output issue_op_t op);
    logic [31:0] r;
    r = $random(seed);
    // Roughly 40% multiplies
    if (r[6:0] < 7'd51) begin
      op.kind = OP_MUL;
    end else begin
      op.kind = op_kind_t'(3'(r[15:8] % 8'd7));
    end
    op.rd    = r[20:16];
    op.src_a = $random(seed);
    op.src_b = $random(seed);
  endtask

  // Called at a falling edge; keeps offering until accepted
  task automatic offer_op(input int gap);
    issue_op_t op;
    int        seen;
    repeat (gap) @(negedge clk_i);
    random_op(op);
    issue_valid_i = 1'b1;
    issue_op_i    = op;
    seen          = accept_count;
    while (accept_count == seen) begin
      @(negedge clk_i);
    end
    issue_valid_i = 1'b0;
  endtask

  initial begin : stimulus
    int gap_max;
    int gap;
    int drain;
    clk_i         = 1'b0;
    rst_i         = 1'b0;
    issue_valid_i = 1'b0;
    issue_op_i    = '0;
    gap_max       = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b1;
    repeat (3) @(negedge clk_i);

    for (int n = 0; n < NUM_OFFERS; n++) begin
      // Alternate dense bursts and sparse stretches
      if (n % 32 == 0) begin
        gap_max = ($random(seed) & 1) ? 0 : 7;
      end
      gap = (gap_max == 0) ? 0 : $unsigned($random(seed)) % (gap_max + 1);
      offer_op(gap);
    end

    drain = 0;
    while (exp_q.size() > 0 && drain < CYCLES_PER_OFFER) begin
      @(negedge clk_i);
      drain++;
    end
    repeat (MUL_STAGES + 4) @(negedge clk_i);

    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("%0d accepted operations were never committed", exp_q.size());
    end
    assert (collision_stalls > 0) else begin
      other_errors++;
      $display("No ALU op was ever held back by a multiply writeback");
    end

    // Failures of the ROB assertions
    other_errors += dut0.rob0.props0.assert_failures;

    $display("Done: %0d commits, %0d value errors, %0d other errors",
             commit_count, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout at %0t: %0d of %0d offers accepted, %0d value errors, %0d other errors",
             $time, accept_count, NUM_OFFERS, value_errors, other_errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* exec_core_properties.sv */
`timescale 1ns/1ps

module exec_core_properties (
  input logic                clk_i,
  input logic                rst_i,
  input logic                alloc_i,
  input logic                full_i,
  input exec_pkg::complete_t alu_done_i,
  input exec_pkg::complete_t mul_done_i,
  input exec_pkg::commit_t   commit_i
);
  import exec_pkg::*;

  localparam int PEND_WIDTH = ROB_IDX_WIDTH + 1;

  int                    assert_failures = 0;
  logic [PEND_WIDTH-1:0] pending_q;

  // Allocations not yet seen on the commit port
  always_ff @(posedge clk_i) begin : pending_flops
    if (!rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_q + PEND_WIDTH'(alloc_i) - PEND_WIDTH'(commit_i.valid);
    end
  end

  // Nothing to commit from an empty buffer
  property p_no_commit_empty;
    @(posedge clk_i) disable iff (!rst_i)
      commit_i.valid |-> (pending_q != '0);
  endproperty

  property p_no_alloc_full;
    @(posedge clk_i) disable iff (!rst_i)
      full_i |-> !alloc_i;
  endproperty

  // Issue keeps the two writebacks apart
  property p_single_completion;
    @(posedge clk_i) disable iff (!rst_i)
      !(alu_done_i.valid && mul_done_i.valid);
  endproperty

  property p_commit_known;
    @(posedge clk_i) disable iff (!rst_i)
      !$isunknown(commit_i.valid);
  endproperty

  a_no_commit_empty: assert property (p_no_commit_empty)
    else begin
      assert_failures++;
      $error("commit_o.valid raised while the ROB was empty");
    end
  a_no_alloc_full: assert property (p_no_alloc_full)
    else begin
      assert_failures++;
      $error("ROB allocation while full");
    end
  a_single_completion: assert property (p_single_completion)
    else begin
      assert_failures++;
      $error("ALU and multiply completions valid in the same cycle");
    end
  a_commit_known: assert property (p_commit_known)
    else begin
      assert_failures++;
      $error("commit_o.valid is unknown after reset");
    end

endmodule

bind reorder_buffer exec_core_properties props0 (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .alloc_i    (alloc_i),
  .full_i     (full_o),
  .alu_done_i (alu_done_i),
  .mul_done_i (mul_done_i),
  .commit_i   (commit_o)
);

/* exec_core.sv */
`timescale 1ns/1ps

module exec_core (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                issue_valid_i,
  input  exec_pkg::issue_op_t issue_op_i,
  output logic                stall_o,
  output exec_pkg::commit_t   commit_o
);
  import exec_pkg::*;

  logic                     rob_full;
  logic                     rob_alloc;
  logic [REG_WIDTH-1:0]     rob_alloc_rd;
  logic [ROB_IDX_WIDTH-1:0] rob_alloc_idx;

  alu_req_t  alu_req;
  complete_t alu_done;
  complete_t mul_done;

  // Entry 0 comes from issue, entry k+1 from stage k
  mul_flow_t mul_flow [MUL_STAGES+1];

  issue_unit issue_unit0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_op_i    (issue_op_i),
    .rob_full_i    (rob_full),
    .rob_idx_i     (rob_alloc_idx),
    .stall_o       (stall_o),
    .alloc_o       (rob_alloc),
    .alloc_rd_o    (rob_alloc_rd),
    .alu_req_o     (alu_req),
    .mul_o         (mul_flow[0])
  );

  alu_unit alu_unit0 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .req_i  (alu_req),
    .done_o (alu_done)
  );

  // ========================================
  // Multiply pipeline
  // ========================================
  for (genvar k = 0; k < MUL_STAGES; k++) begin : g_mul
    mul_stage #(
      .STAGE_IDX (k)
    ) mul_stage0 (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .flow_i (mul_flow[k]),
      .flow_o (mul_flow[k+1])
    );
  end

  assign mul_done.valid   = mul_flow[MUL_STAGES].valid;
  assign mul_done.rob_idx = mul_flow[MUL_STAGES].rob_idx;
  assign mul_done.result  = mul_flow[MUL_STAGES].acc;

  reorder_buffer rob0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .alloc_i     (rob_alloc),
    .alloc_rd_i  (rob_alloc_rd),
    .alu_done_i  (alu_done),
    .mul_done_i  (mul_done),
    .full_o      (rob_full),
    .alloc_idx_o (rob_alloc_idx),
    .commit_o    (commit_o)
  );

endmodule

/* reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               alloc_i,
  input  logic [exec_pkg::REG_WIDTH-1:0]     alloc_rd_i,
  input  exec_pkg::complete_t                alu_done_i,
  input  exec_pkg::complete_t                mul_done_i,
  output logic                               full_o,
  output logic [exec_pkg::ROB_IDX_WIDTH-1:0] alloc_idx_o,
  output exec_pkg::commit_t                  commit_o
);
  import exec_pkg::*;

  logic [REG_WIDTH-1:0]     rd_q     [ROB_DEPTH];
  logic [DATA_WIDTH-1:0]    result_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0]     done_q;
  logic [ROB_IDX_WIDTH-1:0] head_q;
  logic [ROB_IDX_WIDTH-1:0] tail_q;
  logic [ROB_IDX_WIDTH:0]   count_q;

  logic                  empty;
  logic                  alu_hits_head;
  logic                  mul_hits_head;
  logic                  head_ready;
  logic [DATA_WIDTH-1:0] head_result;

  assign empty       = (count_q == '0);
  assign full_o      = (count_q == (ROB_IDX_WIDTH+1)'(ROB_DEPTH));
  assign alloc_idx_o = tail_q;

  // ========================================
  // Head selection
  // ========================================
  // A completion for the head commits on the same edge it is written
  assign alu_hits_head = alu_done_i.valid && (alu_done_i.rob_idx == head_q);
  assign mul_hits_head = mul_done_i.valid && (mul_done_i.rob_idx == head_q);
  assign head_ready    = !empty && (done_q[head_q] || alu_hits_head || mul_hits_head);

  always_comb begin : head_mux
    if (alu_hits_head) begin
      head_result = alu_done_i.result;
    end else if (mul_hits_head) begin
      head_result = mul_done_i.result;
    end else begin
      head_result = result_q[head_q];
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin : entry_data
    if (alloc_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (alu_done_i.valid) begin
      result_q[alu_done_i.rob_idx] <= alu_done_i.result;
    end
    if (mul_done_i.valid) begin
      result_q[mul_done_i.rob_idx] <= mul_done_i.result;
    end
  end

  // ========================================
  // Pointers, done flags and commit
  // ========================================
  always_ff @(posedge clk_i) begin : ctrl_flops
    if (!rst_i) begin
      head_q         <= '0;
      tail_q         <= '0;
      count_q        <= '0;
      done_q         <= '0;
      commit_o.valid <= 1'b0;
    end else begin
      if (alloc_i) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      if (alu_done_i.valid) begin
        done_q[alu_done_i.rob_idx] <= 1'b1;
      end
      if (mul_done_i.valid) begin
        done_q[mul_done_i.rob_idx] <= 1'b1;
      end
      if (head_ready) begin
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end

      case ({alloc_i, head_ready})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase

      commit_o.valid <= head_ready;
      if (head_ready) begin
        commit_o.rd     <= rd_q[head_q];
        commit_o.result <= head_result;
      end
    end
  end

endmodule

/* issue_unit.sv */
`timescale 1ns/1ps

module issue_unit (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  issue_valid_i,
  input  exec_pkg::issue_op_t                   issue_op_i,
  input  logic                                  rob_full_i,
  input  logic [exec_pkg::ROB_IDX_WIDTH-1:0]    rob_idx_i,
  output logic                                  stall_o,
  output logic                                  alloc_o,
  output logic [exec_pkg::REG_WIDTH-1:0]        alloc_rd_o,
  output exec_pkg::alu_req_t                    alu_req_o,
  output exec_pkg::mul_flow_t                   mul_o
);
  import exec_pkg::*;

  localparam int HIST_DEPTH = MUL_STAGES - 1;

  logic                  is_mul;
  logic                  wb_collision;
  logic                  accept;
  logic [HIST_DEPTH-1:0] mul_hist_q;

  // ========================================
  // Stall and acceptance
  // ========================================
  assign is_mul = (issue_op_i.kind == OP_MUL);

  // ALU result would land on the same edge as a multiply result
  assign wb_collision = !is_mul && mul_hist_q[HIST_DEPTH-1];

  assign stall_o    = rob_full_i || wb_collision;
  assign accept     = issue_valid_i && !stall_o;
  assign alloc_o    = accept;
  assign alloc_rd_o = issue_op_i.rd;

  // Multiply acceptances of the last few edges
  always_ff @(posedge clk_i) begin : hist_flops
    if (!rst_i) begin
      mul_hist_q <= '0;
    end else begin
      mul_hist_q <= (mul_hist_q << 1) | HIST_DEPTH'(accept && is_mul);
    end
  end

  // ========================================
  // Dispatch registers
  // ========================================
  always_ff @(posedge clk_i) begin : dispatch_flops
    if (!rst_i) begin
      alu_req_o.valid <= 1'b0;
      mul_o.valid     <= 1'b0;
    end else begin
      alu_req_o.valid <= accept && !is_mul;
      mul_o.valid     <= accept && is_mul;
      if (accept && !is_mul) begin
        alu_req_o.rob_idx <= rob_idx_i;
        alu_req_o.kind    <= issue_op_i.kind;
        alu_req_o.src_a   <= issue_op_i.src_a;
        alu_req_o.src_b   <= issue_op_i.src_b;
      end
      if (accept && is_mul) begin
        mul_o.rob_idx <= rob_idx_i;
        mul_o.mcand   <= issue_op_i.src_a;
        mul_o.mplier  <= issue_op_i.src_b;
        mul_o.acc     <= '0;
      end
    end
  end

endmodule

/* mul_stage.sv */
`timescale 1ns/1ps

module mul_stage #(
  parameter int STAGE_IDX = 0
)(
  input  logic                clk_i,
  input  logic                rst_i,
  input  exec_pkg::mul_flow_t flow_i,
  output exec_pkg::mul_flow_t flow_o
);
  import exec_pkg::*;

  localparam bit LAST_STAGE = (STAGE_IDX == MUL_STAGES - 1);

  logic [DATA_WIDTH-1:0] partial;
  logic [DATA_WIDTH-1:0] acc_next;

  // Multiplicand times the current multiplier slice
  assign partial  = flow_i.mcand * DATA_WIDTH'(flow_i.mplier[MUL_SLICE-1:0]);
  assign acc_next = flow_i.acc + partial;

  always_ff @(posedge clk_i) begin : stage_flops
    if (!rst_i) begin
      flow_o.valid <= 1'b0;
    end else begin
      flow_o.valid <= flow_i.valid;
      if (flow_i.valid) begin
        flow_o.rob_idx <= flow_i.rob_idx;
        flow_o.acc     <= acc_next;
        if (LAST_STAGE) begin
          // Nothing left to consume
          flow_o.mcand  <= '0;
          flow_o.mplier <= '0;
        end else begin
          flow_o.mcand  <= flow_i.mcand << MUL_SLICE;
          flow_o.mplier <= flow_i.mplier >> MUL_SLICE;
        end
      end
    end
  end

endmodule

/* alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
  input  logic                clk_i,
  input  logic                rst_i,
  input  exec_pkg::alu_req_t  req_i,
  output exec_pkg::complete_t done_o
);
  import exec_pkg::*;

  localparam int SHAMT_BITS = $clog2(DATA_WIDTH);

  logic [DATA_WIDTH-1:0] result;
  logic [SHAMT_BITS-1:0] shamt;

  assign shamt = req_i.src_b[SHAMT_BITS-1:0];

  always_comb begin : alu_op
    case (req_i.kind)
      OP_ADD:  result = req_i.src_a + req_i.src_b;
      OP_SUB:  result = req_i.src_a - req_i.src_b;
      OP_AND:  result = req_i.src_a & req_i.src_b;
      OP_OR:   result = req_i.src_a | req_i.src_b;
      OP_XOR:  result = req_i.src_a ^ req_i.src_b;
      OP_SLL:  result = req_i.src_a << shamt;
      // Logical, zero fill
      OP_SRL:  result = req_i.src_a >> shamt;
      // Multiplies never reach this unit
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin : alu_flops
    if (!rst_i) begin
      done_o.valid <= 1'b0;
    end else begin
      done_o.valid <= req_i.valid;
      if (req_i.valid) begin
        done_o.rob_idx <= req_i.rob_idx;
        done_o.result  <= result;
      end
    end
  end

endmodule

/* exec_pkg.sv */
package exec_pkg;

  // ========================================
  // Widths and depths
  // ========================================
  localparam int DATA_WIDTH    = 32;
  localparam int REG_WIDTH     = 5;
  localparam int ROB_DEPTH     = 8;
  localparam int ROB_IDX_WIDTH = 3;
  localparam int MUL_STAGES    = 4;
  localparam int MUL_SLICE     = DATA_WIDTH / MUL_STAGES;

  typedef enum logic [2:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_MUL
  } op_kind_t;

  // ========================================
  // Shared structs
  // ========================================
  typedef struct packed {
    op_kind_t              kind;
    logic [REG_WIDTH-1:0]  rd;
    logic [DATA_WIDTH-1:0] src_a;
    logic [DATA_WIDTH-1:0] src_b;
  } issue_op_t;

  typedef struct packed {
    logic                     valid;
    logic [ROB_IDX_WIDTH-1:0] rob_idx;
    op_kind_t                 kind;
    logic [DATA_WIDTH-1:0]    src_a;
    logic [DATA_WIDTH-1:0]    src_b;
  } alu_req_t;

  // Multiply state between stages
  typedef struct packed {
    logic                     valid;
    logic [ROB_IDX_WIDTH-1:0] rob_idx;
    logic [DATA_WIDTH-1:0]    mcand;
    logic [DATA_WIDTH-1:0]    mplier;
    logic [DATA_WIDTH-1:0]    acc;
  } mul_flow_t;

  typedef struct packed {
    logic                     valid;
    logic [ROB_IDX_WIDTH-1:0] rob_idx;
    logic [DATA_WIDTH-1:0]    result;
  } complete_t;

  typedef struct packed {
    logic                  valid;
    logic [REG_WIDTH-1:0]  rd;
    logic [DATA_WIDTH-1:0] result;
  } commit_t;

endpackage
